// ==== hdl/rv_isa_pkg.sv ====
// RV32 ISA constants used by the branch unit
// Word and immediate widths, B-type condition codes

package rv_isa_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int XLEN  = 32;  // Data and address word
   localparam int IMM_W = 12;  // Raw I and B immediates, as decoded

   // Common word and raw immediate
   typedef logic [XLEN-1:0]  word_t;
   typedef logic [IMM_W-1:0] imm_t;

   ////////////////////////////////////////
   // B-type conditions
   ////////////////////////////////////////
   // Codes 3'b010 and 3'b011 are illegal
   typedef enum logic [2:0] {
      F3_BEQ  = 3'b000,  // Equal
      F3_BNE  = 3'b001,  // Not equal
      F3_BLT  = 3'b100,  // Less than, signed
      F3_BGE  = 3'b101,  // Greater or equal, signed
      F3_BLTU = 3'b110,  // Less than, unsigned
      F3_BGEU = 3'b111   // Greater or equal, unsigned
   } funct3_t;

   // Increment to the next sequential instruction
   localparam word_t INSTR_BYTES = word_t'(4);

endpackage

// ==== hdl/bu_pkg.sv ====
// Branch unit types
// Candidate target pair and the operand compare flags

package bu_pkg;

   ////////////////////////////////////////
   // Target addresses
   ////////////////////////////////////////
   // Both candidates, the stage picks one
   typedef struct packed {
      rv_isa_pkg::word_t taken_pc;     // PC+immB, or JALR address
      rv_isa_pkg::word_t fallthru_pc;  // PC+4
   } target_pair_t;

   ////////////////////////////////////////
   // Compare flags
   ////////////////////////////////////////
   // Equality made locally, less-than flags from ALU
   typedef struct packed {
      logic eq;           // op0 == op1
      logic lt_unsigned;  // op0 < op1 unsigned
      logic lt_signed;    // op0 < op1 signed
   } cmp_flags_t;

endpackage

// ==== hdl/bu_instr_if.sv ====
// Decoded jump/branch instruction bundle
// Fed from the top level ports, read by resolver, target calc and stage
// Clock and reset ride along for the checks in the readers

interface bu_instr_if (
   input logic clk,      // Clock
   input logic aresetn   // Async reset, active low
);

   rv_isa_pkg::word_t   pc;            // Instruction PC
   logic                is_b_type;     // B-type class
   logic                is_jalr;       // JALR only
   logic                is_j_or_jalr;  // JAL or JALR
   rv_isa_pkg::funct3_t funct3;        // Branch condition
   rv_isa_pkg::imm_t    imm_i;         // Raw I immediate
   rv_isa_pkg::imm_t    imm_b;         // Raw B immediate, halfword units
   rv_isa_pkg::word_t   op0;           // rs1 value
   rv_isa_pkg::word_t   op1;           // rs2 value
   logic                lt_unsigned;   // From ALU
   logic                lt_signed;     // From ALU

   ////////////////////////////////////////
   // Views
   ////////////////////////////////////////
   // Condition resolver
   modport resolver (
      input clk, aresetn,
      input is_b_type, is_j_or_jalr, funct3,
      input op0, op1, lt_unsigned, lt_signed
   );

   // Target calculator
   modport target (
      input clk, aresetn,
      input pc, is_b_type, is_jalr, is_j_or_jalr,
      input imm_i, imm_b, op0
   );

   // Branch stage
   modport stage (
      input pc, is_jalr, is_b_type, is_j_or_jalr
   );

endinterface

// ==== hdl/branch_cond_resolver.sv ====
// Branch condition resolver
// Decides taken/not taken for JAL, JALR and the six B-type conditions
// Purely combinational

module branch_cond_resolver (
   bu_instr_if.resolver bi,       // Decoded instruction
   output logic         o_taken   // Resolved direction
);

   bu_pkg::cmp_flags_t flags;  // Operand compare results

   ////////////////////////////////////////
   // Compare flags
   ////////////////////////////////////////
   // ALU has no equality output, compare here
   assign flags.eq          = (bi.op0 == bi.op1);
   assign flags.lt_unsigned = bi.lt_unsigned;  // ALU unsigned compare
   assign flags.lt_signed   = bi.lt_signed;    // ALU signed compare

   ////////////////////////////////////////
   // Direction
   ////////////////////////////////////////
   always_comb begin
      o_taken = 1'b0;  // Default not taken
      case ({bi.is_j_or_jalr, bi.is_b_type})
         // JAL or JALR, unconditional
         2'b10: begin
            o_taken = 1'b1;
         end
         // Conditional branch
         2'b01: begin
            case (bi.funct3)
               rv_isa_pkg::F3_BEQ:  o_taken =  flags.eq;
               rv_isa_pkg::F3_BNE:  o_taken = ~flags.eq;
               rv_isa_pkg::F3_BLT:  o_taken =  flags.lt_signed;
               rv_isa_pkg::F3_BGE:  o_taken = ~flags.lt_signed;
               rv_isa_pkg::F3_BLTU: o_taken =  flags.lt_unsigned;
               rv_isa_pkg::F3_BGEU: o_taken = ~flags.lt_unsigned;
               // Illegal code, predictor also says not taken
               default:             o_taken = 1'b0;
            endcase
         end
         // No jump/branch in the slot
         default: begin
            o_taken = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   // Decoder must never flag both classes for one slot
   a_class_onehot : assert property (
      @(posedge bi.clk) disable iff (!bi.aresetn)
      !(bi.is_b_type && bi.is_j_or_jalr)
   ) else $error("branch_cond_resolver: B-type and jump flagged together");

endmodule

// ==== hdl/branch_target_calc.sv ====
// Branch target calculator
// Sign-extends the raw immediates and forms PC+4 and the taken target
// JALR target is op0+immI with bit 0 cleared, else PC+immB

module branch_target_calc (
   bu_instr_if.target           bi,         // Decoded instruction
   output bu_pkg::target_pair_t o_targets   // Both candidate targets
);

   localparam int EXT_W = rv_isa_pkg::XLEN - rv_isa_pkg::IMM_W;  // Sign fill

   rv_isa_pkg::word_t imm_i_sx;       // I immediate, sign-extended
   rv_isa_pkg::word_t imm_b_sx;       // B immediate, x2 and sign-extended
   rv_isa_pkg::word_t pc_plus_4;      // Sequential PC
   rv_isa_pkg::word_t pc_plus_imm_b;  // Conditional branch target
   rv_isa_pkg::word_t op0_plus_imm_i; // JALR raw sum
   rv_isa_pkg::word_t jalr_addr;      // JALR target, LSB cleared

   ////////////////////////////////////////
   // Immediates
   ////////////////////////////////////////
   assign imm_i_sx = {{EXT_W{bi.imm_i[rv_isa_pkg::IMM_W-1]}}, bi.imm_i};

   // Raw B immediate counts halfwords, shift left by one
   assign imm_b_sx = {{EXT_W{bi.imm_b[rv_isa_pkg::IMM_W-1]}},
                      bi.imm_b[rv_isa_pkg::IMM_W-2:0], 1'b0};

   ////////////////////////////////////////
   // Adders
   ////////////////////////////////////////
   assign pc_plus_4      = bi.pc + rv_isa_pkg::INSTR_BYTES;
   assign pc_plus_imm_b  = bi.pc + imm_b_sx;
   assign op0_plus_imm_i = bi.op0 + imm_i_sx;

   // Spec says drop bit 0 of the JALR sum
   assign jalr_addr = op0_plus_imm_i & ~rv_isa_pkg::word_t'(1);

   // Taken target by class
   assign o_targets.taken_pc    = bi.is_jalr ? jalr_addr : pc_plus_imm_b;
   assign o_targets.fallthru_pc = pc_plus_4;  // Also the link address

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   // JALR must come marked as a jump and never as a B-type
   a_jalr_is_jump : assert property (
      @(posedge bi.clk) disable iff (!bi.aresetn)
      bi.is_jalr |-> (bi.is_j_or_jalr && !bi.is_b_type)
   ) else $error("branch_target_calc: JALR without jump class");

endmodule

// ==== hdl/branch_stage.sv ====
// Branch stage
// Picks the branch PC, registers the resolved results with stall hold
// Compares resolved vs predicted direction and raises a one-cycle flush

module branch_stage #(
   parameter rv_isa_pkg::word_t PC_INIT = '0  // Reset value of both PCs
) (
   input  logic                 clk,             // Clock
   input  logic                 aresetn,         // Async reset, active low
   input  logic                 i_stall,         // Hold all registers
   input  logic                 i_bubble,        // Empty input slot
   input  logic                 i_pred_taken,    // Fetch-stage prediction
   bu_instr_if.stage            bi,              // Decoded class flags and PC
   input  logic                 i_taken,         // From condition resolver
   input  bu_pkg::target_pair_t i_targets,       // From target calculator
   output rv_isa_pkg::word_t    o_nxt_instr_pc,  // Return address, PC+4
   output rv_isa_pkg::word_t    o_branch_pc,     // Resolved branch PC
   output logic                 o_branch_taken,  // Resolved direction
   output logic                 o_bubble,        // Bubble out
   output logic                 o_flush          // Mispredict flush
);

   rv_isa_pkg::word_t branch_pc;        // Selected branch PC
   logic              bubble;           // Outgoing bubble, unregistered
   logic              flush;            // Direction mismatch

   rv_isa_pkg::word_t nxt_instr_pc_rg;
   rv_isa_pkg::word_t branch_pc_rg;
   logic              taken_rg;         // Resolved direction
   logic              pred_taken_rg;    // Prediction for same slot
   logic              bubble_rg;
   logic              en_cmp_rg;        // Compare enable

   ////////////////////////////////////////
   // Next-stage values
   ////////////////////////////////////////
   // JAL lands on PC+4 here since fetch already followed it
   assign branch_pc = (bi.is_jalr || (bi.is_b_type && i_taken)) ?
                      i_targets.taken_pc : i_targets.fallthru_pc;

   // Only jumps write back a link, everything else leaves as bubble
   assign bubble = bi.is_j_or_jalr ? i_bubble : 1'b1;

   ////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge aresetn) begin
      if (!aresetn) begin
         nxt_instr_pc_rg <= PC_INIT;
         branch_pc_rg    <= PC_INIT;
         taken_rg        <= 1'b0;
         pred_taken_rg   <= 1'b0;
         bubble_rg       <= 1'b1;  // Empty slot out of reset
      end else if (!i_stall) begin
         nxt_instr_pc_rg <= i_targets.fallthru_pc;
         branch_pc_rg    <= branch_pc;
         taken_rg        <= i_taken;
         pred_taken_rg   <= i_pred_taken;
         bubble_rg       <= bubble;
      end
   end

   // Compare enable
   // Cleared right after a flush, even under stall, so flush is a pulse
   always_ff @(posedge clk or negedge aresetn) begin
      if (!aresetn) begin
         en_cmp_rg <= 1'b0;
      end else if (flush) begin
         en_cmp_rg <= 1'b0;
      end else if (!i_stall) begin
         en_cmp_rg <= ~i_bubble;  // Bubbled slot never compares
      end
   end

   ////////////////////////////////////////
   // Flush
   ////////////////////////////////////////
   assign flush = en_cmp_rg & (taken_rg ^ pred_taken_rg);

   // Outputs
   assign o_nxt_instr_pc = nxt_instr_pc_rg;
   assign o_branch_pc    = branch_pc_rg;
   assign o_branch_taken = taken_rg;
   assign o_bubble       = bubble_rg;
   assign o_flush        = flush;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   // Flush is a single-cycle pulse
   a_flush_pulse : assert property (
      @(posedge clk) disable iff (!aresetn)
      o_flush |=> !o_flush
   ) else $error("branch_stage: flush held for two cycles");

   // Flush only follows an accepted, non-bubbled slot
   a_flush_cause : assert property (
      @(posedge clk) disable iff (!aresetn)
      o_flush |-> $past(!i_stall && !i_bubble)
   ) else $error("branch_stage: flush without a compared slot");

endmodule

// ==== hdl/exu_branch_unit.sv ====
// Execution unit branch-resolution stage, top level
// Packs the decoded jump/branch ports into the instruction bundle
// Resolver and target calc feed the registered branch stage

module exu_branch_unit #(
   parameter rv_isa_pkg::word_t PC_INIT = '0  // Reset PC for both PC outputs
) (
   input  logic              clk,                // Clock
   input  logic              aresetn,            // Async reset, active low
   input  logic              i_stall,            // Stall, holds outputs
   input  logic              i_bubble,           // Empty input slot
   input  rv_isa_pkg::word_t i_pc,               // Instruction PC
   input  logic              i_is_b_type,        // B-type class
   input  logic              i_is_jalr,          // JALR
   input  logic              i_is_j_or_jalr,     // JAL or JALR
   input  logic [2:0]        i_funct3,           // Branch funct3
   input  rv_isa_pkg::imm_t  i_imm_i,            // Raw I immediate
   input  rv_isa_pkg::imm_t  i_imm_b,            // Raw B immediate
   input  rv_isa_pkg::word_t i_op0,              // rs1
   input  rv_isa_pkg::word_t i_op1,              // rs2
   input  logic              i_op0_lt_op1,       // ALU unsigned less-than
   input  logic              i_sign_op0_lt_op1,  // ALU signed less-than
   input  logic              i_pred_taken,       // Fetch-stage prediction
   output rv_isa_pkg::word_t o_nxt_instr_pc,     // PC+4, link address
   output rv_isa_pkg::word_t o_branch_pc,        // Resolved branch PC
   output logic              o_branch_taken,     // Resolved direction
   output logic              o_bubble,           // Bubble out
   output logic              o_flush             // Mispredict flush
);

   logic                 taken;    // Resolver -> stage
   bu_pkg::target_pair_t targets;  // Target calc -> stage

   ////////////////////////////////////////
   // Instruction bundle
   ////////////////////////////////////////
   bu_instr_if u_instr_if (
      .clk     (clk),
      .aresetn (aresetn)
   );

   assign u_instr_if.pc           = i_pc;
   assign u_instr_if.is_b_type    = i_is_b_type;
   assign u_instr_if.is_jalr      = i_is_jalr;
   assign u_instr_if.is_j_or_jalr = i_is_j_or_jalr;
   assign u_instr_if.funct3       = rv_isa_pkg::funct3_t'(i_funct3);  // Raw code, may be illegal
   assign u_instr_if.imm_i        = i_imm_i;
   assign u_instr_if.imm_b        = i_imm_b;
   assign u_instr_if.op0          = i_op0;
   assign u_instr_if.op1          = i_op1;
   assign u_instr_if.lt_unsigned  = i_op0_lt_op1;
   assign u_instr_if.lt_signed    = i_sign_op0_lt_op1;

   ////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////
   branch_cond_resolver u_branch_cond_resolver (
      .bi      (u_instr_if),
      .o_taken (taken)
   );

   branch_target_calc u_branch_target_calc (
      .bi        (u_instr_if),
      .o_targets (targets)
   );

   branch_stage #(
      .PC_INIT (PC_INIT)
   ) u_branch_stage (
      .clk            (clk),
      .aresetn        (aresetn),
      .i_stall        (i_stall),
      .i_bubble       (i_bubble),
      .i_pred_taken   (i_pred_taken),
      .bi             (u_instr_if),
      .i_taken        (taken),
      .i_targets      (targets),
      .o_nxt_instr_pc (o_nxt_instr_pc),
      .o_branch_pc    (o_branch_pc),
      .o_branch_taken (o_branch_taken),
      .o_bubble       (o_bubble),
      .o_flush        (o_flush)
   );

endmodule

// ==== include/tb_branch_model.svh ====
// Reference model of the branch stage
// Expected output registers and compare enable, stepped once per edge

`ifndef TB_BRANCH_MODEL_SVH
`define TB_BRANCH_MODEL_SVH

rv_isa_pkg::word_t m_nxt_pc;     // Expected o_nxt_instr_pc
rv_isa_pkg::word_t m_branch_pc;  // Expected o_branch_pc
logic              m_taken;      // Expected o_branch_taken
logic              m_pred;       // Registered prediction
logic              m_bubble;     // Expected o_bubble
logic              m_en_cmp;     // Compare enable

// Reset state
function automatic void reset_model(input rv_isa_pkg::word_t pc_init);
   m_nxt_pc    = pc_init;
   m_branch_pc = pc_init;
   m_taken     = 1'b0;
   m_pred      = 1'b0;
   m_bubble    = 1'b1;
   m_en_cmp    = 1'b0;
endfunction

// Expected o_flush from current registers
function automatic logic expected_flush();
   return m_en_cmp & (m_taken ^ m_pred);
endfunction

// Advance by one rising edge with the inputs seen at that edge
function automatic void step_model(
   input logic stall, input logic bub, input logic pred_in, input rv_isa_pkg::word_t pc,
   input logic is_b, input logic is_jalr, input logic is_j, input logic [2:0] f3,
   input rv_isa_pkg::imm_t imm_i, input rv_isa_pkg::imm_t imm_b,
   input rv_isa_pkg::word_t op0, input rv_isa_pkg::word_t op1);
   logic              t;
   logic              fl;
   rv_isa_pkg::word_t ii;
   rv_isa_pkg::word_t ib;
   rv_isa_pkg::word_t tgt;
   fl = expected_flush();
   ii = rv_isa_pkg::word_t'($signed(imm_i));       // Sign-extended I immediate
   ib = rv_isa_pkg::word_t'($signed(imm_b)) << 1;  // Halfwords to bytes
   case (f3)
      3'b000:  t = (op0 == op1);
      3'b001:  t = (op0 != op1);
      3'b100:  t = ($signed(op0) < $signed(op1));
      3'b101:  t = ($signed(op0) >= $signed(op1));
      3'b110:  t = (op0 < op1);
      3'b111:  t = (op0 >= op1);
      default: t = 1'b0;
   endcase
   t = is_j ? 1'b1 : (is_b ? t : 1'b0);  // Jumps always taken
   if (is_jalr) tgt = (op0 + ii) & ~32'd1;
   else if (is_b && t) tgt = pc + ib;
   else tgt = pc + 32'd4;  // JAL and not taken
   if (fl) m_en_cmp = 1'b0;
   else if (!stall) m_en_cmp = ~bub;
   if (!stall) begin
      m_nxt_pc    = pc + 32'd4;
      m_branch_pc = tgt;
      m_taken     = t;
      m_pred      = pred_in;
      m_bubble    = is_j ? bub : 1'b1;
   end
endfunction

`endif

// ==== verification/tb_exu_branch_unit.sv ====
// Testbench for the branch-resolution stage
// Random jumps and branches from a fixed seed, checked each cycle against a model
// Covers stall hold, bubble rule and the one-cycle flush

module tb_exu_branch_unit;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int                PERIOD      = 4;             // ns
   localparam int                RST_CYCLES  = 2;
   localparam int                N_CYCLES    = 4000;          // Random cycles
   localparam int                WATCHDOG_NS = (N_CYCLES + RST_CYCLES) * PERIOD + 200;
   localparam rv_isa_pkg::word_t TB_PC_INIT  = 32'h0000_1000;  // Non-zero reset PC

   logic              clk;
   logic              aresetn;
   logic              stall;
   logic              bubble;
   rv_isa_pkg::word_t pc;
   logic              is_b_type;
   logic              is_jalr;
   logic              is_j_or_jalr;
   logic [2:0]        funct3;
   rv_isa_pkg::imm_t  imm_i;
   rv_isa_pkg::imm_t  imm_b;
   rv_isa_pkg::word_t op0;
   rv_isa_pkg::word_t op1;
   logic              lt_u;        // ALU flags, derived from operands
   logic              lt_s;
   logic              pred_taken;
   rv_isa_pkg::word_t nxt_instr_pc;
   rv_isa_pkg::word_t branch_pc;
   logic              branch_taken;
   logic              bubble_out;
   logic              flush;
   int                errors;

   `include "tb_branch_model.svh"

   exu_branch_unit #(
      .PC_INIT (TB_PC_INIT)
   ) u_exu_branch_unit (
      .clk               (clk),
      .aresetn           (aresetn),
      .i_stall           (stall),
      .i_bubble          (bubble),
      .i_pc              (pc),
      .i_is_b_type       (is_b_type),
      .i_is_jalr         (is_jalr),
      .i_is_j_or_jalr    (is_j_or_jalr),
      .i_funct3          (funct3),
      .i_imm_i           (imm_i),
      .i_imm_b           (imm_b),
      .i_op0             (op0),
      .i_op1             (op1),
      .i_op0_lt_op1      (lt_u),
      .i_sign_op0_lt_op1 (lt_s),
      .i_pred_taken      (pred_taken),
      .o_nxt_instr_pc    (nxt_instr_pc),
      .o_branch_pc       (branch_pc),
      .o_branch_taken    (branch_taken),
      .o_bubble          (bubble_out),
      .o_flush           (flush)
   );

   ////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog timeout");
   end

   // First error ends the run
   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping on first error");
   endtask

   // Every output against the model
   task automatic check_outputs();
      assert (nxt_instr_pc === m_nxt_pc)
         else report_mismatch("o_nxt_instr_pc", nxt_instr_pc, m_nxt_pc);
      assert (branch_pc === m_branch_pc)
         else report_mismatch("o_branch_pc", branch_pc, m_branch_pc);
      assert (branch_taken === m_taken)
         else report_mismatch("o_branch_taken", 32'(branch_taken), 32'(m_taken));
      assert (bubble_out === m_bubble)
         else report_mismatch("o_bubble", 32'(bubble_out), 32'(m_bubble));
      assert (flush === expected_flush())
         else report_mismatch("o_flush", 32'(flush), 32'(expected_flush()));
   endtask

   // New random slot, class 0 none, 1 B-type, 2 JAL, 3 JALR
   task automatic drive_random();
      logic [1:0]        cls;
      rv_isa_pkg::word_t tmp;
      cls          = 2'($urandom_range(0, 3));
      is_b_type    = (cls == 2'd1);
      is_j_or_jalr = (cls == 2'd2) || (cls == 2'd3);
      is_jalr      = (cls == 2'd3);
      funct3       = 3'($urandom_range(0, 7));  // Illegal codes too
      imm_i        = rv_isa_pkg::imm_t'($urandom);
      imm_b        = rv_isa_pkg::imm_t'($urandom);
      tmp          = $urandom;
      pc           = {tmp[31:2], 2'b00};  // Word aligned
      op0          = $urandom;
      op1          = ($urandom_range(0, 3) == 0) ? op0 : $urandom;  // Equal pair 1 in 4
      lt_u         = (op0 < op1);
      lt_s         = ($signed(op0) < $signed(op1));
      stall        = ($urandom_range(0, 99) < 20);
      bubble       = ($urandom_range(0, 99) < 15);
      pred_taken   = 1'($urandom_range(0, 1));
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      void'($urandom(18));  // Seed once
      errors       = 0;
      aresetn      = 1'b0;
      stall        = 1'b0;
      bubble       = 1'b1;
      pc           = '0;
      is_b_type    = 1'b0;
      is_jalr      = 1'b0;
      is_j_or_jalr = 1'b0;
      funct3       = 3'b000;
      imm_i        = '0;
      imm_b        = '0;
      op0          = '0;
      op1          = '0;
      lt_u         = 1'b0;
      lt_s         = 1'b0;
      pred_taken   = 1'b0;
      reset_model(TB_PC_INIT);
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      check_outputs();  // Reset values
      aresetn = 1'b1;
      drive_random();
      repeat (N_CYCLES) begin
         @(posedge clk);
         step_model(stall, bubble, pred_taken, pc, is_b_type, is_jalr, is_j_or_jalr,
                    funct3, imm_i, imm_b, op0, op1);
         #1;  // Outputs settled, drive next slot
         check_outputs();
         drive_random();
      end
      if (errors == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Simulation finished: FAIL");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== flist.f ====
+incdir+include
hdl/rv_isa_pkg.sv
hdl/bu_pkg.sv
hdl/bu_instr_if.sv
hdl/branch_cond_resolver.sv
hdl/branch_target_calc.sv
hdl/branch_stage.sv
hdl/exu_branch_unit.sv
verification/tb_exu_branch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_exu_branch_unit \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_exu_branch_unit > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
[ -s sim.log ] || { echo "No simulation log"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && exit 1
exit 0
